//--- snakePkg.sv
// shared coordinate, colour, direction and pixel-write types plus default game geometry
`default_nettype none

package snakePkg;

    // screen column, 0 to 159 on the default screen
    typedef logic [7:0] xCoord_t;

    // screen row, 0 to 119 on the default screen
    typedef logic [6:0] yCoord_t;

    // 3-bit rgb colour
    typedef logic [2:0] colour_t;

    // one screen point, x in the upper bits
    typedef struct packed {
        xCoord_t x;
        yCoord_t y;
    } point_t;

    // encoding follows the old key order, right first
    typedef enum logic [1:0] {
        dirRight,
        dirDown,
        dirUp,
        dirLeft
    } direction_t;

    // one pixel write towards the frame buffer
    typedef struct packed {
        point_t  pos;
        colour_t colour;
    } pixelWrite_t;

    // default geometry, overridden from the top level
    localparam int DEFAULT_SCREEN_W  = 160;
    localparam int DEFAULT_SCREEN_H  = 120;
    localparam int DEFAULT_SEG_SIZE  = 10;
    localparam int DEFAULT_SEG_COUNT = 6;

    // fixed colours
    localparam colour_t APPLE_COLOUR      = 3'b100;
    localparam colour_t BACKGROUND_COLOUR = 3'b000;

    // head start point and the apple corner
    localparam point_t START_HEAD = '{x: 8'd80, y: 7'd60};
    localparam point_t APPLE_POS  = '{x: 8'd30, y: 7'd30};

endpackage

`default_nettype wire

//--- snakeBody.sv
// direction register, head stepping and head-position history with segment taps
`default_nettype none

module snakeBody #(
    parameter int SCREEN_W  = snakePkg::DEFAULT_SCREEN_W,
    parameter int SCREEN_H  = snakePkg::DEFAULT_SCREEN_H,
    parameter int SEG_SIZE  = snakePkg::DEFAULT_SEG_SIZE,
    parameter int SEG_COUNT = snakePkg::DEFAULT_SEG_COUNT
) (
    input  wire logic                                 Clock,
    input  wire logic                                 reset,
    input  wire snakePkg::direction_t                 turn,
    input  wire logic                                 turnValid,
    input  wire logic                                 step,
    output snakePkg::point_t [SEG_COUNT-1:0]          segments
);

    import snakePkg::*;

    // one history entry per pixel of travel
    localparam int HIST_DEPTH = SEG_COUNT * SEG_SIZE;

    direction_t direction;
    point_t     history [HIST_DEPTH];
    point_t     nextHead;

    // manhattan distance between two points
    function automatic int stepDistance(point_t a, point_t b);
        int dx;
        int dy;
        dx = int'(a.x) - int'(b.x);
        dy = int'(a.y) - int'(b.y);
        if (dx < 0)
            dx = -dx;
        if (dy < 0)
            dy = -dy;
        return dx + dy;
    endfunction

    // latest request wins, applied at the next step
    always_ff @(posedge Clock)
    begin
        if (reset)
            direction <= dirRight;
        else if (turnValid)
            direction <= turn;
    end

    // new head, one pixel away from the current one
    always_comb
    begin
        nextHead = history[0];
        case (direction)
            dirRight: nextHead.x = history[0].x + 1'b1;
            dirDown:  nextHead.y = history[0].y + 1'b1;
            dirUp:    nextHead.y = history[0].y - 1'b1;
            dirLeft:  nextHead.x = history[0].x - 1'b1;
            default:  nextHead = history[0];
        endcase
    end

    // trailing history, entry 0 is the head
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            // straight line to the left of the start point
            for (int i = 0; i < HIST_DEPTH; i++)
            begin
                history[i].x <= xCoord_t'(START_HEAD.x - i);
                history[i].y <= START_HEAD.y;
            end
        end
        else if (step)
        begin
            history[0] <= nextHead;
            // oldest entry drops off the end
            for (int i = 1; i < HIST_DEPTH; i++)
                history[i] <= history[i-1];
        end
    end

    // segment k sits k*SEG_SIZE steps back
    for (genvar k = 0; k < SEG_COUNT; k++)
    begin : gSegTap
        assign segments[k] = history[k*SEG_SIZE];
    end

    // one pixel per step, and the head square never leaves the screen
    assert property (@(posedge Clock) disable iff (reset)
        step |=> (stepDistance($past(history[0]), history[0]) == 1)
                 && (int'(history[0].x) <= SCREEN_W - SEG_SIZE)
                 && (int'(history[0].y) <= SCREEN_H - SEG_SIZE))
        else $error("head step is not a single on-screen pixel");

endmodule

`default_nettype wire

//--- collisionCheck.sv
// registered head self-overlap and wall test
`default_nettype none

module collisionCheck #(
    parameter int SCREEN_W  = snakePkg::DEFAULT_SCREEN_W,
    parameter int SCREEN_H  = snakePkg::DEFAULT_SCREEN_H,
    parameter int SEG_SIZE  = snakePkg::DEFAULT_SEG_SIZE,
    parameter int SEG_COUNT = snakePkg::DEFAULT_SEG_COUNT
) (
    input  wire logic                                 Clock,
    input  wire logic                                 reset,
    input  wire logic                                 checkStrobe,
    input  wire snakePkg::point_t [SEG_COUNT-1:0]     segments,
    output logic                                      hit
);

    import snakePkg::*;

    logic selfHit;
    logic wallHit;

    // two SEG_SIZE squares share at least one pixel
    function automatic logic squaresOverlap(point_t a, point_t b);
        logic xOver;
        logic yOver;
        xOver = (int'(a.x) < int'(b.x) + SEG_SIZE) && (int'(a.x) + SEG_SIZE > int'(b.x));
        yOver = (int'(a.y) < int'(b.y) + SEG_SIZE) && (int'(a.y) + SEG_SIZE > int'(b.y));
        return xOver && yOver;
    endfunction

    // segment 1 always touches the head, so start at 2
    always_comb
    begin
        selfHit = 1'b0;
        for (int k = 2; k < SEG_COUNT; k++)
        begin
            if (squaresOverlap(segments[0], segments[k]))
                selfHit = 1'b1;
        end
    end

    // head square on any screen edge
    assign wallHit = (segments[0].x == '0)
                  || (segments[0].y == '0)
                  || (int'(segments[0].x) == SCREEN_W - SEG_SIZE)
                  || (int'(segments[0].y) == SCREEN_H - SEG_SIZE);

    // result held until the next request
    always_ff @(posedge Clock)
    begin
        if (reset)
            hit <= 1'b0;
        else if (checkStrobe)
            hit <= selfHit || wallHit;
    end

    // result only ever updates right after a request
    assert property (@(posedge Clock) disable iff (reset)
        !$past(checkStrobe) |-> $stable(hit))
        else $error("hit changed without a check request");

endmodule

`default_nettype wire

//--- frameRenderer.sv
// game sequence FSM, frame tick counter, pixel counters and pixel address generation
`default_nettype none

module frameRenderer #(
    parameter int SCREEN_W    = snakePkg::DEFAULT_SCREEN_W,
    parameter int SCREEN_H    = snakePkg::DEFAULT_SCREEN_H,
    parameter int SEG_SIZE    = snakePkg::DEFAULT_SEG_SIZE,
    parameter int SEG_COUNT   = snakePkg::DEFAULT_SEG_COUNT,
    parameter int FRAME_TICKS = 1000000
) (
    input  wire logic                                 Clock,
    input  wire logic                                 reset,
    input  wire logic                                 start,
    input  wire snakePkg::colour_t                    snakeColour,
    input  wire snakePkg::point_t [SEG_COUNT-1:0]     segments,
    input  wire logic                                 hit,
    output logic                                      step,
    output logic                                      checkStrobe,
    output snakePkg::pixelWrite_t                     pixel,
    output logic                                      plot,
    output logic                                      gameOver
);

    import snakePkg::*;

    localparam int TICK_W = (FRAME_TICKS > 1) ? $clog2(FRAME_TICKS) : 1;
    localparam int OFS_W  = (SEG_SIZE > 1) ? $clog2(SEG_SIZE) : 1;
    localparam int SEG_W  = (SEG_COUNT > 1) ? $clog2(SEG_COUNT) : 1;

    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(FRAME_TICKS - 1);
    localparam logic [OFS_W-1:0]  LAST_OFS  = OFS_W'(SEG_SIZE - 1);
    localparam logic [SEG_W-1:0]  LAST_SEG  = SEG_W'(SEG_COUNT - 1);

    typedef enum logic [3:0] {
        idle,
        waitDraw,
        drawApple,
        drawBody,
        waitErase,
        eraseBody,
        check,
        decide,
        advance,
        over
    } state_t;

    state_t state;
    state_t nextState;

    logic [TICK_W-1:0] tickCount;
    logic              tick;

    // offsets inside the current square, and which segment
    logic [OFS_W-1:0]  col;
    logic [OFS_W-1:0]  row;
    logic [SEG_W-1:0]  segIdx;
    logic              squareDone;
    logic              lastSeg;
    point_t            corner;

    // free-running frame tick
    always_ff @(posedge Clock)
    begin
        if (reset)
            tickCount <= '0;
        else if (tick)
            tickCount <= '0;
        else
            tickCount <= tickCount + 1'b1;
    end

    assign tick = (tickCount == LAST_TICK);

    assign squareDone = (col == LAST_OFS) && (row == LAST_OFS);
    assign lastSeg    = (segIdx == LAST_SEG);

    always_ff @(posedge Clock)
    begin
        if (reset)
            state <= idle;
        else
            state <= nextState;
    end

    always_comb
    begin
        nextState = state;
        case (state)
            idle:
                if (start)
                    nextState = waitDraw;
            // first frame waits for a tick
            waitDraw:
                if (tick)
                    nextState = drawApple;
            drawApple:
                if (squareDone)
                    nextState = drawBody;
            drawBody:
                if (squareDone && lastSeg)
                    nextState = waitErase;
            // body stays visible until the next tick
            waitErase:
                if (tick)
                    nextState = eraseBody;
            eraseBody:
                if (squareDone && lastSeg)
                    nextState = check;
            // collisionCheck registers here
            check:
                nextState = decide;
            decide:
                if (hit)
                    nextState = over;
                else
                    nextState = advance;
            // snake moves, next frame starts straight away
            advance:
                nextState = drawApple;
            // held until reset
            over:
                nextState = over;
            default:
                nextState = idle;
        endcase
    end

    assign plot        = (state == drawApple) || (state == drawBody) || (state == eraseBody);
    assign step        = (state == advance);
    assign checkStrobe = (state == check);
    assign gameOver    = (state == over);

    // raster walk, column fastest, then row, then segment
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            col    <= '0;
            row    <= '0;
            segIdx <= '0;
        end
        else if (plot)
        begin
            if (col == LAST_OFS)
            begin
                col <= '0;
                if (row == LAST_OFS)
                begin
                    row <= '0;
                    // apple is a single square
                    if (state == drawApple || lastSeg)
                        segIdx <= '0;
                    else
                        segIdx <= segIdx + 1'b1;
                end
                else
                    row <= row + 1'b1;
            end
            else
                col <= col + 1'b1;
        end
    end

    // square corner plus offsets, colour by phase
    always_comb
    begin
        corner       = segments[segIdx];
        pixel.colour = snakeColour;
        case (state)
            drawApple:
            begin
                corner       = APPLE_POS;
                pixel.colour = APPLE_COLOUR;
            end
            eraseBody:
                pixel.colour = BACKGROUND_COLOUR;
            default:
                pixel.colour = snakeColour;
        endcase
        pixel.pos.x = corner.x + xCoord_t'(col);
        pixel.pos.y = corner.y + yCoord_t'(row);
    end

    // nothing drawn before start or after the game ends
    assert property (@(posedge Clock) disable iff (reset)
        (state == idle || state == over) |-> !plot)
        else $error("plot raised outside a game");

    // snake position from snakeBody keeps every write on screen
    assert property (@(posedge Clock) disable iff (reset)
        plot |-> (int'(pixel.pos.x) < SCREEN_W) && (int'(pixel.pos.y) < SCREEN_H))
        else $error("plotted pixel off screen");

endmodule

`default_nettype wire

//--- snakeGame.sv
// snake game top level joining body, collision check and renderer
`default_nettype none

module snakeGame #(
    parameter int SCREEN_W    = snakePkg::DEFAULT_SCREEN_W,
    parameter int SCREEN_H    = snakePkg::DEFAULT_SCREEN_H,
    parameter int SEG_SIZE    = snakePkg::DEFAULT_SEG_SIZE,
    parameter int SEG_COUNT   = snakePkg::DEFAULT_SEG_COUNT,
    parameter int FRAME_TICKS = 1000000
) (
    input  wire logic                   Clock,
    input  wire logic                   reset,
    input  wire logic                   start,
    input  wire snakePkg::direction_t   turn,
    input  wire logic                   turnValid,
    input  wire snakePkg::colour_t      snakeColour,
    output snakePkg::pixelWrite_t       pixel,
    output logic                        plot,
    output logic                        gameOver
);

    import snakePkg::*;

    // head first
    point_t [SEG_COUNT-1:0] segments;
    logic                   step;
    logic                   checkStrobe;
    logic                   hit;

    // positions, moved on step
    snakeBody #(
        .SCREEN_W  (SCREEN_W),
        .SCREEN_H  (SCREEN_H),
        .SEG_SIZE  (SEG_SIZE),
        .SEG_COUNT (SEG_COUNT)
    ) snakeBody_i (
        .Clock     (Clock),
        .reset     (reset),
        .turn      (turn),
        .turnValid (turnValid),
        .step      (step),
        .segments  (segments)
    );

    // head against walls and its own tail
    collisionCheck #(
        .SCREEN_W    (SCREEN_W),
        .SCREEN_H    (SCREEN_H),
        .SEG_SIZE    (SEG_SIZE),
        .SEG_COUNT   (SEG_COUNT)
    ) collisionCheck_i (
        .Clock       (Clock),
        .reset       (reset),
        .checkStrobe (checkStrobe),
        .segments    (segments),
        .hit         (hit)
    );

    // sequencing and pixel output
    frameRenderer #(
        .SCREEN_W    (SCREEN_W),
        .SCREEN_H    (SCREEN_H),
        .SEG_SIZE    (SEG_SIZE),
        .SEG_COUNT   (SEG_COUNT),
        .FRAME_TICKS (FRAME_TICKS)
    ) frameRenderer_i (
        .Clock       (Clock),
        .reset       (reset),
        .start       (start),
        .snakeColour (snakeColour),
        .segments    (segments),
        .hit         (hit),
        .step        (step),
        .checkStrobe (checkStrobe),
        .pixel       (pixel),
        .plot        (plot),
        .gameOver    (gameOver)
    );

endmodule

`default_nettype wire

//--- tbSnakeChecks.sv
// concurrent checks and shadow head model for the snake game testbench
`default_nettype none

module tbSnakeChecks #(
    parameter int SCREEN_W  = snakePkg::DEFAULT_SCREEN_W,
    parameter int SCREEN_H  = snakePkg::DEFAULT_SCREEN_H,
    parameter int SEG_SIZE  = snakePkg::DEFAULT_SEG_SIZE,
    parameter int SEG_COUNT = snakePkg::DEFAULT_SEG_COUNT
) (
    input  wire logic                   Clock,
    input  wire logic                   reset,
    input  wire logic                   start,
    input  wire snakePkg::direction_t   turn,
    input  wire logic                   turnValid,
    input  wire snakePkg::colour_t      snakeColour,
    input  wire snakePkg::pixelWrite_t  pixel,
    input  wire logic                   plot,
    input  wire logic                   gameOver,
    output logic                        failed
);
    timeunit 1ns;
    timeprecision 1ps;

    import snakePkg::*;

    localparam int APPLE_N = SEG_SIZE * SEG_SIZE;
    localparam int BODY_N  = SEG_COUNT * APPLE_N;

    // pixels seen so far in the current frame, per phase
    int         appleCount;
    int         bodyCount;
    int         eraseCount;
    point_t     bodyPix [BODY_N];
    point_t     expectedHead;
    direction_t reqDir;
    logic       started;
    logic       atWall;
    logic       isApple;
    logic       isBody;
    logic       isErase;
    logic       newFrame;
    logic       failSeen = 1'b0;

    // head corner after one pixel of travel
    function automatic point_t movedPoint(point_t p, direction_t d);
        point_t q;
        q = p;
        case (d)
            dirRight: q.x = p.x + 8'd1;
            dirLeft:  q.x = p.x - 8'd1;
            dirDown:  q.y = p.y + 7'd1;
            default:  q.y = p.y - 7'd1;
        endcase
        return q;
    endfunction

    // head square touching any screen border
    function automatic logic onScreenEdge(point_t p);
        return (p.x == '0) || (p.y == '0)
            || (int'(p.x) == SCREEN_W - SEG_SIZE) || (int'(p.y) == SCREEN_H - SEG_SIZE);
    endfunction

    task automatic flagMismatch(input string what);
        $display("mismatch at %0t: %s", $time, what);
        failSeen = 1'b1;
    endtask

    assign failed   = failSeen;
    assign isApple  = plot && (pixel.colour == APPLE_COLOUR);
    assign isBody   = plot && (pixel.colour == snakeColour);
    assign isErase  = plot && (pixel.colour == BACKGROUND_COLOUR);
    // apple after a finished erase opens a new frame
    assign newFrame = isApple && (eraseCount == BODY_N);

    always @(posedge Clock)
    begin
        if (reset)
        begin
            appleCount   <= 0;
            bodyCount    <= 0;
            eraseCount   <= 0;
            expectedHead <= START_HEAD;
            reqDir       <= dirRight;
            started      <= 1'b0;
            atWall       <= 1'b0;
        end
        else
        begin
            if (start)
                started <= 1'b1;
            if (turnValid)
                reqDir <= turn;
            if (newFrame)
            begin
                appleCount   <= 1;
                bodyCount    <= 0;
                eraseCount   <= 0;
                // one step in the last requested direction
                expectedHead <= movedPoint(expectedHead, reqDir);
            end
            else if (isApple)
                appleCount <= appleCount + 1;
            if (isBody && bodyCount < BODY_N)
            begin
                bodyPix[bodyCount] <= pixel.pos;
                bodyCount          <= bodyCount + 1;
                // modelled head on an edge ends the game this frame
                if (bodyCount == 0)
                    atWall <= onScreenEdge(expectedHead);
            end
            if (isErase)
                eraseCount <= eraseCount + 1;
        end
    end

    assert property (@(posedge Clock) disable iff (reset)
        plot |-> (int'(pixel.pos.x) < SCREEN_W) && (int'(pixel.pos.y) < SCREEN_H))
        else flagMismatch("plotted pixel off screen");

    assert property (@(posedge Clock) disable iff (reset)
        plot |-> isApple || isBody || isErase)
        else flagMismatch("pixel colour belongs to no phase");

    // apple square first, exactly once per frame
    assert property (@(posedge Clock) disable iff (reset)
        isApple |-> (pixel.pos.x >= APPLE_POS.x) && (int'(pixel.pos.x) < APPLE_POS.x + SEG_SIZE)
                 && (pixel.pos.y >= APPLE_POS.y) && (int'(pixel.pos.y) < APPLE_POS.y + SEG_SIZE)
                 && (newFrame || (bodyCount == 0 && appleCount < APPLE_N)))
        else flagMismatch("apple pixel misplaced or out of order");

    assert property (@(posedge Clock) disable iff (reset)
        isApple |-> !atWall)
        else flagMismatch("apple drawn after the head reached a wall");

    assert property (@(posedge Clock) disable iff (reset)
        isBody |-> (appleCount == APPLE_N) && (eraseCount == 0) && (bodyCount < BODY_N))
        else flagMismatch("body pixel count or order wrong");

    // first body pixel is the head corner
    assert property (@(posedge Clock) disable iff (reset)
        (isBody && bodyCount == 0) |-> (pixel.pos == expectedHead))
        else flagMismatch("head corner not where the model expects");

    // erase replays the body pass pixel by pixel
    assert property (@(posedge Clock) disable iff (reset)
        isErase |-> (bodyCount == BODY_N) && (eraseCount < BODY_N)
                 && (pixel.pos == bodyPix[eraseCount]))
        else flagMismatch("erase pixel differs from body pass");

    assert property (@(posedge Clock) disable iff (reset)
        gameOver |-> atWall && !plot)
        else flagMismatch("game over without wall contact, or plot after it");

    assert property (@(posedge Clock)
        reset |=> !plot && !gameOver)
        else flagMismatch("plot or gameOver high right after reset");

    assert property (@(posedge Clock) disable iff (reset)
        !started |-> !plot && !gameOver)
        else flagMismatch("activity before start");

endmodule

`default_nettype wire

//--- tbSnakeGame.sv
// testbench top with clock, reset, LFSR turn stimulus, DUT instance, checker and watchdog
`default_nettype none

module tbSnakeGame;
    timeunit 1ns;
    timeprecision 1ps;

    import snakePkg::*;

    localparam int          CLOCK_PERIOD  = 4;
    localparam int          RESET_CYCLES  = 16;
    localparam int          SEG_SIZE      = 10;
    localparam int          SEG_COUNT     = 4;
    localparam int          FRAME_TICKS   = 64;
    localparam int          RANDOM_FRAMES = 16;
    localparam int          CLIMB_FRAMES  = 32;
    localparam int          LEFT_FRAMES   = 100;
    localparam colour_t     SNAKE_COLOUR  = 3'b010;
    localparam logic [31:0] SEED          = 32'h20e7_fb31;

    // apple plus draw and erase of every segment, one tick wait, a few control cycles
    localparam int FRAME_CYCLES = SEG_SIZE * SEG_SIZE * (1 + 2 * SEG_COUNT) + FRAME_TICKS + 8;
    localparam int TOTAL_FRAMES = RANDOM_FRAMES + CLIMB_FRAMES + LEFT_FRAMES + 4;
    localparam longint WATCHDOG_NS =
        longint'(RESET_CYCLES + 300 + TOTAL_FRAMES * FRAME_CYCLES) * CLOCK_PERIOD;

    logic        Clock;
    logic        reset;
    logic        start;
    direction_t  turn;
    logic        turnValid;
    colour_t     snakeColour;
    pixelWrite_t pixel;
    logic        plot;
    logic        gameOver;
    logic        checksFailed;
    logic [31:0] lfsrState;

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic takeBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            value     = (value << 1) | int'(lfsrState[0]);
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic requestTurn(input direction_t dir);
        turn      <= dir;
        turnValid <= 1'b1;
        @(posedge Clock);
        turnValid <= 1'b0;
    endtask

    // first apple pixel of the next frame
    task automatic waitFrameStart();
        do
            @(posedge Clock);
        while (plot && pixel.colour == APPLE_COLOUR);
        do
            @(posedge Clock);
        while (!(plot && pixel.colour == APPLE_COLOUR));
    endtask

    always #(CLOCK_PERIOD / 2) Clock = ~Clock;

    snakeGame #(
        .SEG_SIZE    (SEG_SIZE),
        .SEG_COUNT   (SEG_COUNT),
        .FRAME_TICKS (FRAME_TICKS)
    ) snakeGame_i (
        .Clock       (Clock),
        .reset       (reset),
        .start       (start),
        .turn        (turn),
        .turnValid   (turnValid),
        .snakeColour (snakeColour),
        .pixel       (pixel),
        .plot        (plot),
        .gameOver    (gameOver)
    );

    tbSnakeChecks #(
        .SEG_SIZE    (SEG_SIZE),
        .SEG_COUNT   (SEG_COUNT)
    ) checks_i (
        .Clock       (Clock),
        .reset       (reset),
        .start       (start),
        .turn        (turn),
        .turnValid   (turnValid),
        .snakeColour (snakeColour),
        .pixel       (pixel),
        .plot        (plot),
        .gameOver    (gameOver),
        .failed      (checksFailed)
    );

    initial
    begin
        int delay;
        int pick;
        Clock       = 1'b0;
        reset       = 1'b1;
        start       = 1'b0;
        turn        = dirRight;
        turnValid   = 1'b0;
        snakeColour = SNAKE_COLOUR;
        lfsrState   = SEED;
        repeat (RESET_CYCLES) @(posedge Clock);
        reset <= 1'b0;
        // idle gap before start
        repeat (4) @(posedge Clock);
        start <= 1'b1;
        @(posedge Clock);
        start <= 1'b0;
        // staircase of right and up turns, no self overlap possible
        for (int f = 0; f < RANDOM_FRAMES; f++)
        begin
            waitFrameStart();
            takeBits(8, delay);
            takeBits(1, pick);
            // lands inside apple or body draw, well before the step
            repeat (delay) @(posedge Clock);
            requestTurn(pick != 0 ? dirUp : dirRight);
        end
        // long climb so the whole body is one column
        waitFrameStart();
        requestTurn(dirUp);
        repeat (CLIMB_FRAMES) waitFrameStart();
        // head for the left wall
        requestTurn(dirLeft);
        wait (gameOver);
        // plot must stay low from here on
        repeat (300) @(posedge Clock);
        if (checksFailed)
        begin
            $display("Simulation FAILED");
            $fatal(1, "a testbench check failed");
        end
        else
        begin
            $display("Simulation PASSED");
            $finish;
        end
    end

    // stop at the first failed check
    initial
    begin
        wait (checksFailed);
        $display("Simulation FAILED");
        $fatal(1, "a testbench check failed");
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the game ended at the wall");
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- tb.f
snakePkg.sv
snakeBody.sv
collisionCheck.sv
frameRenderer.sv
snakeGame.sv
tbSnakeChecks.sv
tbSnakeGame.sv

//--- run.sh
#!/bin/sh
# build and run the snake game testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tbSnakeGame -f tb.f \
    && ./obj_dir/VtbSnakeGame > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation PASSED" sim.log && exit 0 || exit 1
